// ==== Bender.yml ====
package:
  name: cache_macros

sources:
  - logic/mem_pkg.sv
  - logic/sram_if.sv
  - logic/byte_ram.sv
  - logic/dir_array.sv
  - logic/lane_ram.sv
  - logic/btb_table.sv
  - logic/cache_macros.sv
  - target: test
    files:
      - test/tb_cache_macros.sv

// ==== files.f ====
logic/mem_pkg.sv
logic/sram_if.sv
logic/byte_ram.sv
logic/dir_array.sv
logic/lane_ram.sv
logic/btb_table.sv
logic/cache_macros.sv
test/tb_cache_macros.sv

// ==== logic/btb_table.sv ====
`timescale 1ns/10ps

module btb_table import mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  w_en,
  input  logic [BTB_ADDR_W-1:0] w_addr,
  input  way_mask_t             w_mask,
  input  btb_row_t              w_data,
  input  logic                  r_en,
  input  logic [BTB_ADDR_W-1:0] r_addr,
  output btb_row_t              r_data
);

  btb_row_t mem [2**BTB_ADDR_W];
  btb_row_t bit_en;

  // Lane mask to per-bit enables
  always_comb begin
    for (int l = 0; l < BTB_LANES; l++) begin
      bit_en[l] = {$bits(btb_lane_t){w_mask[l]}};
    end
  end

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[w_addr] <= (mem[w_addr] & ~bit_en) | (w_data & bit_en);
    end
  end

  ////////////////////
  // Read port
  ////////////////////
  // Same-address write lands after this sample, so reads see old data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_data <= '0;
    end else if (r_en) begin
      r_data <= mem[r_addr];
    end
  end

  a_waddr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    w_en |-> !$isunknown(w_addr)
  );

endmodule

// ==== logic/byte_ram.sv ====
`timescale 1ns/10ps

module byte_ram import mem_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  sram_if.memory port
);

  logic [RAM_WORD_W-1:0] mem [2**DIR_ADDR_W];

  ////////////////////
  // Byte-masked write
  ////////////////////
  always_ff @(posedge clk) begin
    if (port.en && port.wmode) begin
      for (int b = 0; b < RAM_BYTES; b++) begin
        if (port.wmask[b]) begin
          mem[port.addr][b*8 +: 8] <= port.wdata[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////
  // Registered read
  ////////////////////
  // Output holds through writes and idle cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      port.rdata <= '0;
    end else if (port.en && !port.wmode) begin
      port.rdata <= mem[port.addr];
    end
  end

  a_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    port.en |-> !$isunknown(port.addr)
  );

endmodule

// ==== logic/cache_macros.sv ====
`timescale 1ns/10ps

module cache_macros import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  // Coherence directory
  input  logic                      dir_en,
  input  logic                      dir_wmode,
  input  logic [DIR_ADDR_W-1:0]     dir_addr,
  input  dir_row_t                  dir_wdata,
  input  dir_mask_t                 dir_wmask,
  output dir_row_t                  dir_rdata,
  // Data-cache tags
  input  logic                      dtag_en,
  input  logic                      dtag_wmode,
  input  logic [TAG_ADDR_W-1:0]     dtag_addr,
  input  dtag_t [TAG_WAYS-1:0]      dtag_wdata,
  input  way_mask_t                 dtag_wmask,
  output dtag_t [TAG_WAYS-1:0]      dtag_rdata,
  // Instruction-cache tags
  input  logic                      itag_en,
  input  logic                      itag_wmode,
  input  logic [TAG_ADDR_W-1:0]     itag_addr,
  input  itag_t [TAG_WAYS-1:0]      itag_wdata,
  input  way_mask_t                 itag_wmask,
  output itag_t [TAG_WAYS-1:0]      itag_rdata,
  // BTB table
  input  logic                      btb_w_en,
  input  logic [BTB_ADDR_W-1:0]     btb_w_addr,
  input  way_mask_t                 btb_w_mask,
  input  btb_row_t                  btb_w_data,
  input  logic                      btb_r_en,
  input  logic [BTB_ADDR_W-1:0]     btb_r_addr,
  output btb_row_t                  btb_r_data
);

  ////////////////////
  // Request buses
  ////////////////////
  sram_if #(
    .addr_t(logic [DIR_ADDR_W-1:0]),
    .data_t(dir_row_t),
    .mask_t(dir_mask_t)
  ) dir_if ();

  sram_if #(
    .addr_t(logic [TAG_ADDR_W-1:0]),
    .data_t(dtag_t [TAG_WAYS-1:0]),
    .mask_t(way_mask_t)
  ) dtag_if ();

  sram_if #(
    .addr_t(logic [TAG_ADDR_W-1:0]),
    .data_t(itag_t [TAG_WAYS-1:0]),
    .mask_t(way_mask_t)
  ) itag_if ();

  assign dir_if.en     = dir_en;
  assign dir_if.wmode  = dir_wmode;
  assign dir_if.addr   = dir_addr;
  assign dir_if.wdata  = dir_wdata;
  assign dir_if.wmask  = dir_wmask;
  assign dir_rdata     = dir_if.rdata;

  assign dtag_if.en    = dtag_en;
  assign dtag_if.wmode = dtag_wmode;
  assign dtag_if.addr  = dtag_addr;
  assign dtag_if.wdata = dtag_wdata;
  assign dtag_if.wmask = dtag_wmask;
  assign dtag_rdata    = dtag_if.rdata;

  assign itag_if.en    = itag_en;
  assign itag_if.wmode = itag_wmode;
  assign itag_if.addr  = itag_addr;
  assign itag_if.wdata = itag_wdata;
  assign itag_if.wmask = itag_wmask;
  assign itag_rdata    = itag_if.rdata;

  ////////////////////
  // Macros
  ////////////////////
  dir_array u_dir (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (dir_if.memory)
  );

  lane_ram #(
    .lane_t (dtag_t),
    .LANES  (TAG_WAYS),
    .DEPTH  (2**TAG_ADDR_W)
  ) u_dtag (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (dtag_if.memory)
  );

  lane_ram #(
    .lane_t (itag_t),
    .LANES  (TAG_WAYS),
    .DEPTH  (2**TAG_ADDR_W)
  ) u_itag (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (itag_if.memory)
  );

  btb_table u_btb (
    .clk    (clk),
    .rst_n  (rst_n),
    .w_en   (btb_w_en),
    .w_addr (btb_w_addr),
    .w_mask (btb_w_mask),
    .w_data (btb_w_data),
    .r_en   (btb_r_en),
    .r_addr (btb_r_addr),
    .r_data (btb_r_data)
  );

endmodule

// ==== logic/dir_array.sv ====
`timescale 1ns/10ps

module dir_array import mem_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  sram_if.memory req
);

  logic [DIR_WORDS*RAM_WORD_W-1:0] pad_wdata;
  logic [DIR_WORDS*RAM_WORD_W-1:0] pad_rdata;
  logic [DIR_WORDS*RAM_BYTES-1:0]  pad_be;
  dir_row_t                        rd_row;

  ////////////////////
  // Lane packing
  ////////////////////
  // Each lane owns a 24-bit slot with the gap in the top nibble.
  // Lane 2 and lane 5 cross a word boundary.
  always_comb begin
    pad_wdata = '0;
    for (int i = 0; i < DIR_LANES; i++) begin
      pad_wdata[i*($bits(dir_lane_t)+DIR_GAP_W) +: $bits(dir_lane_t)] = req.wdata[i];
    end
  end

  // Three bytes per slot, so a straddling lane enables bytes in both words
  always_comb begin
    for (int b = 0; b < DIR_WORDS*RAM_BYTES; b++) begin
      pad_be[b] = req.wmask[(b*8) / ($bits(dir_lane_t)+DIR_GAP_W)];
    end
  end

  // Gather lanes back and drop the gaps
  always_comb begin
    for (int i = 0; i < DIR_LANES; i++) begin
      rd_row[i] = pad_rdata[i*($bits(dir_lane_t)+DIR_GAP_W) +: $bits(dir_lane_t)];
    end
  end

  assign req.rdata = rd_row;

  ////////////////////
  // RAM words
  ////////////////////
  for (genvar w = 0; w < DIR_WORDS; w++) begin : g_word
    sram_if #(
      .addr_t(logic [DIR_ADDR_W-1:0]),
      .data_t(logic [RAM_WORD_W-1:0]),
      .mask_t(logic [RAM_BYTES-1:0])
    ) word_if ();

    assign word_if.en    = req.en;
    assign word_if.wmode = req.wmode;
    assign word_if.addr  = req.addr;
    assign word_if.wdata = pad_wdata[w*RAM_WORD_W +: RAM_WORD_W];
    assign word_if.wmask = pad_be[w*RAM_BYTES +: RAM_BYTES];

    assign pad_rdata[w*RAM_WORD_W +: RAM_WORD_W] = word_if.rdata;

    byte_ram u_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .port  (word_if.memory)
    );
  end

  a_wmask_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req.en && req.wmode) |-> !$isunknown(req.wmask)
  );

endmodule

// ==== logic/lane_ram.sv ====
`timescale 1ns/10ps

module lane_ram import mem_pkg::*; #(
  parameter type lane_t = dtag_t,
  parameter int  LANES  = TAG_WAYS,
  parameter int  DEPTH  = 2**TAG_ADDR_W
) (
  input logic    clk,
  input logic    rst_n,
  sram_if.memory req
);

  lane_t [LANES-1:0] rd_row;

  ////////////////////
  // Lane columns
  ////////////////////
  // One column per way, written only when its mask bit is set
  for (genvar l = 0; l < LANES; l++) begin : g_col
    lane_t col [DEPTH];

    always_ff @(posedge clk) begin
      if (req.en && req.wmode && req.wmask[l]) begin
        col[req.addr] <= req.wdata[l];
      end
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        rd_row[l] <= '0;
      end else if (req.en && !req.wmode) begin
        rd_row[l] <= col[req.addr];
      end
    end
  end

  // All ways return together as one row
  assign req.rdata = rd_row;

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

  ////////////////////
  // Generic RAM word
  ////////////////////
  localparam int RAM_WORD_W = 64;
  localparam int RAM_BYTES  = 8;

  ////////////////////
  // Coherence directory
  ////////////////////
  localparam int DIR_LANES  = 8;
  localparam int DIR_ADDR_W = 10;
  localparam int DIR_WORDS  = 3;
  // Padding after each lane so lanes line up with byte enables
  localparam int DIR_GAP_W  = 4;

  typedef logic [19:0]                 dir_lane_t;
  typedef dir_lane_t [DIR_LANES-1:0]   dir_row_t;
  typedef logic [DIR_LANES-1:0]        dir_mask_t;

  ////////////////////
  // Cache tag arrays
  ////////////////////
  localparam int TAG_WAYS   = 4;
  localparam int TAG_ADDR_W = 6;

  typedef logic [21:0]         dtag_t;
  typedef logic [19:0]         itag_t;
  typedef logic [TAG_WAYS-1:0] way_mask_t;

  ////////////////////
  // Branch target buffer
  ////////////////////
  localparam int BTB_LANES  = 4;
  localparam int BTB_ADDR_W = 7;

  typedef logic [13:0]               btb_lane_t;
  typedef btb_lane_t [BTB_LANES-1:0] btb_row_t;

endpackage

// ==== logic/sram_if.sv ====
`timescale 1ns/10ps

interface sram_if #(
  parameter type addr_t = logic,
  parameter type data_t = logic,
  parameter type mask_t = logic
);

  logic  en;
  logic  wmode;
  addr_t addr;
  data_t wdata;
  mask_t wmask;
  data_t rdata;

  modport requester (
    output en,
    output wmode,
    output addr,
    output wdata,
    output wmask,
    input  rdata
  );

  modport memory (
    input  en,
    input  wmode,
    input  addr,
    input  wdata,
    input  wmask,
    output rdata
  );

endinterface

// ==== test/tb_cache_macros.sv ====
`timescale 1ns/10ps

module tb_cache_macros import mem_pkg::*; ();

  localparam int DIR_ROWS = 32;
  localparam int DIR_OPS  = 200;
  localparam int TAG_OPS  = 150;
  localparam int BTB_OPS  = 200;
  localparam int TOTAL_CYCLES = 16 + 4 + 2*DIR_ROWS + DIR_OPS + 2*(2**TAG_ADDR_W) + TAG_OPS
                                + 2**BTB_ADDR_W + BTB_OPS + 4;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic dir_en, dir_wmode;
  logic [DIR_ADDR_W-1:0] dir_addr;
  dir_row_t dir_wdata, dir_rdata;
  dir_mask_t dir_wmask;
  logic dtag_en, dtag_wmode, itag_en, itag_wmode;
  logic [TAG_ADDR_W-1:0] dtag_addr, itag_addr;
  dtag_t [TAG_WAYS-1:0] dtag_wdata, dtag_rdata;
  itag_t [TAG_WAYS-1:0] itag_wdata, itag_rdata;
  way_mask_t dtag_wmask, itag_wmask, btb_w_mask;
  logic btb_w_en, btb_r_en;
  logic [BTB_ADDR_W-1:0] btb_w_addr, btb_r_addr;
  btb_row_t btb_w_data, btb_r_data;

  int seed = 16107;
  int err_dir = 0;
  int err_dtag = 0;
  int err_itag = 0;
  int err_btb = 0;

  cache_macros u_dut (.*);

  always #50 clk = ~clk;

  ////////////////////
  // Shadow model
  ////////////////////
  dir_row_t dir_mem [2**DIR_ADDR_W];
  dtag_t [TAG_WAYS-1:0] dtag_mem [2**TAG_ADDR_W];
  itag_t [TAG_WAYS-1:0] itag_mem [2**TAG_ADDR_W];
  btb_row_t btb_mem [2**BTB_ADDR_W];
  dir_row_t exp_dir;
  dtag_t [TAG_WAYS-1:0] exp_dtag;
  itag_t [TAG_WAYS-1:0] exp_itag;
  btb_row_t exp_btb;

  // Nonblocking updates make the model read-first
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_dir  <= '0;
      exp_dtag <= '0;
      exp_itag <= '0;
      exp_btb  <= '0;
    end else begin
      if (dir_en && !dir_wmode) exp_dir <= dir_mem[dir_addr];
      if (dtag_en && !dtag_wmode) exp_dtag <= dtag_mem[dtag_addr];
      if (itag_en && !itag_wmode) exp_itag <= itag_mem[itag_addr];
      if (btb_r_en) exp_btb <= btb_mem[btb_r_addr];
    end
    for (int i = 0; i < DIR_LANES; i++) begin
      if (dir_en && dir_wmode && dir_wmask[i]) dir_mem[dir_addr][i] <= dir_wdata[i];
    end
    for (int w = 0; w < TAG_WAYS; w++) begin
      if (dtag_en && dtag_wmode && dtag_wmask[w]) dtag_mem[dtag_addr][w] <= dtag_wdata[w];
      if (itag_en && itag_wmode && itag_wmask[w]) itag_mem[itag_addr][w] <= itag_wdata[w];
    end
    for (int l = 0; l < BTB_LANES; l++) begin
      if (btb_w_en && btb_w_mask[l]) btb_mem[btb_w_addr][l] <= btb_w_data[l];
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  // rdata must track the model every cycle, so holds and reset zeros are covered too
  a_dir: assert property (@(posedge clk) disable iff (!rst_n) dir_rdata === exp_dir)
    else begin
      err_dir++;
      $display("Fail dir_read expected %h actual %h", $sampled(exp_dir), $sampled(dir_rdata));
    end
  a_dtag: assert property (@(posedge clk) disable iff (!rst_n) dtag_rdata === exp_dtag)
    else begin
      err_dtag++;
      $display("Fail dtag_read expected %h actual %h", $sampled(exp_dtag), $sampled(dtag_rdata));
    end
  a_itag: assert property (@(posedge clk) disable iff (!rst_n) itag_rdata === exp_itag)
    else begin
      err_itag++;
      $display("Fail itag_read expected %h actual %h", $sampled(exp_itag), $sampled(itag_rdata));
    end
  a_btb: assert property (@(posedge clk) disable iff (!rst_n) btb_r_data === exp_btb)
    else begin
      err_btb++;
      $display("Fail btb_read expected %h actual %h", $sampled(exp_btb), $sampled(btb_r_data));
    end

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic clear_inputs();
    {dir_en, dir_wmode, dir_addr, dir_wdata, dir_wmask} = '0;
    {dtag_en, dtag_wmode, dtag_addr, dtag_wdata, dtag_wmask} = '0;
    {itag_en, itag_wmode, itag_addr, itag_wdata, itag_wmask} = '0;
    {btb_w_en, btb_w_addr, btb_w_mask, btb_w_data, btb_r_en, btb_r_addr} = '0;
  endtask

  task automatic dir_cycle(input logic wr, input int addr, input dir_mask_t mask);
    @(negedge clk);
    clear_inputs();
    dir_en    = 1'b1;
    dir_wmode = wr;
    dir_addr  = addr;
    dir_wmask = mask;
    for (int i = 0; i < DIR_LANES; i++) dir_wdata[i] = $random(seed);
  endtask

  task automatic tag_cycle(input logic wr, input int d_addr, input int i_addr,
                           input logic rnd_mask);
    @(negedge clk);
    clear_inputs();
    {dtag_en, itag_en} = 2'b11;
    {dtag_wmode, itag_wmode} = {wr, wr};
    dtag_addr  = d_addr;
    itag_addr  = i_addr;
    dtag_wmask = rnd_mask ? way_mask_t'($random(seed)) : '1;
    itag_wmask = rnd_mask ? way_mask_t'($random(seed)) : '1;
    for (int w = 0; w < TAG_WAYS; w++) begin
      dtag_wdata[w] = $random(seed);
      itag_wdata[w] = $random(seed);
    end
  endtask

  task automatic btb_cycle(input logic rd, input int w_addr, input int r_addr,
                           input logic rnd_mask);
    @(negedge clk);
    clear_inputs();
    btb_w_en   = 1'b1;
    btb_w_addr = w_addr;
    btb_w_mask = rnd_mask ? way_mask_t'($random(seed)) : '1;
    btb_r_en   = rd;
    btb_r_addr = r_addr;
    for (int l = 0; l < BTB_LANES; l++) btb_w_data[l] = $random(seed);
  endtask

  initial begin
    clear_inputs();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    // Directory rows written in full and read back
    for (int a = 0; a < DIR_ROWS; a++) dir_cycle(1'b1, a, '1);
    for (int a = 0; a < DIR_ROWS; a++) dir_cycle(1'b0, a, '0);
    for (int n = 0; n < DIR_OPS; n++) begin
      dir_cycle($random(seed), $unsigned($random(seed)) % DIR_ROWS, $random(seed));
    end
    // Tag arrays
    for (int a = 0; a < 2**TAG_ADDR_W; a++) tag_cycle(1'b1, a, a, 1'b0);
    for (int n = 0; n < TAG_OPS; n++) begin
      tag_cycle($random(seed), $unsigned($random(seed)) % 64,
                $unsigned($random(seed)) % 64, 1'b1);
    end
    for (int a = 0; a < 2**TAG_ADDR_W; a++) tag_cycle(1'b0, a, 63 - a, 1'b0);
    // Every fourth BTB cycle reads the row being written
    for (int a = 0; a < 2**BTB_ADDR_W; a++) btb_cycle(1'b0, a, 0, 1'b0);
    for (int n = 0; n < BTB_OPS; n++) begin
      btb_cycle($random(seed), n % 16,
                (n % 4 == 0) ? n % 16 : $unsigned($random(seed)) % 16, 1'b1);
      if (n % 4 == 0) btb_r_en = 1'b1;
    end
    @(negedge clk);
    clear_inputs();
    repeat (3) @(negedge clk);
    $display("Errors: dir=%0d dtag=%0d itag=%0d btb=%0d", err_dir, err_dtag, err_itag, err_btb);
    if (err_dir + err_dtag + err_itag + err_btb == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(2.0 * TOTAL_CYCLES * 100);
    $display("Timeout: stimulus did not finish in the expected time");
    $display("sim failed");
    $finish;
  end

endmodule
